// ==== erx.f ====
+incdir+include
design/erx_pkg.sv
design/erx_cfg_if.sv
design/erx_cfg.sv
design/erx_protocol.sv
design/erx_remap.sv
design/erx_disty.sv
design/erx_fifo.sv
design/erx.sv
sim/erx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the erx testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f erx.f --top-module erx_tb -Mdir obj_dir -o erx_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/erx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   exit 1
fi
exit 0

// ==== sim/erx_tb.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_tb;

   localparam int TIMEOUT   = 500;           // Cycles allowed per wait
   localparam int RUN_LIMIT = 20000;         // Cycles for the whole run

   logic                  sys_clk = 1'b0;
   logic                  arst_n;
   logic                  link_frame;
   logic [63:0]           link_data;
   logic                  link_wr_wait;
   logic                  link_rd_wait;
   logic                  rxwr_access;
   logic                  rxrd_access;
   logic                  rxrr_access;
   logic [`ERX_PW-1:0]    rxwr_packet;
   logic [`ERX_PW-1:0]    rxrd_packet;
   logic [`ERX_PW-1:0]    rxrr_packet;
   logic                  rxwr_wait;
   logic                  rxrd_wait;
   logic                  rxrr_wait;
   logic                  mi_en;
   logic                  mi_we;
   logic [`ERX_MI_AW-1:0] mi_addr;
   logic [31:0]           mi_din;
   logic [31:0]           mi_dout;

   integer                seed = 32'h174bd4fe;
   int                    errors = 0;
   int                    checks = 0;
   logic                  abort = 1'b0;      // Raised by a timed out wait
   erx_pkg::erx_packet_t  wr_q[$];           // Expected rxwr traffic
   erx_pkg::erx_packet_t  rd_q[$];           // Expected rxrd traffic
   erx_pkg::erx_packet_t  rr_q[$];           // Expected rxrr traffic
   erx_pkg::erx_remap_e   cfg_mode;          // Model of the remap registers
   logic [11:0]           cfg_pattern;
   logic [11:0]           cfg_sel;
   logic [31:0]           cfg_base;

   always #10 sys_clk = ~sys_clk;

   erx i_dut (.*);

   task automatic check_packet(input string name, input erx_pkg::erx_packet_t exp,
                               input erx_pkg::erx_packet_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("error %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic wait_failed(input string what);
      errors++;
      abort = 1'b1;
      $display("timeout while waiting for %s", what);
   endtask

   task automatic unexpected(input string port);
      errors++;
      $display("access on %s with no packet expected there", port);
   endtask

   // Expected packet from the classification and remap rules
   function automatic void predict(input erx_pkg::erx_packet_t p);
      erx_pkg::erx_packet_t e;
      logic                 to_id;
      e        = p;
      e.access = 1'b1;
      to_id    = p.write && (p.dstaddr[31:20] == `ERX_ID);
      if (!to_id && cfg_mode == erx_pkg::REMAP_STATIC)
      begin
         for (int i = 0; i < 12; i++)
            if (cfg_sel[i])
               e.dstaddr[20 + i] = cfg_pattern[i];  // Select picks pattern bit
      end
      else if (!to_id && cfg_mode == erx_pkg::REMAP_OFFSET)
         e.dstaddr = p.dstaddr + cfg_base;
      if (to_id)
         rr_q.push_back(e);
      else if (p.write)
         wr_q.push_back(e);
      else
         rd_q.push_back(e);
   endfunction

   // Scoreboard sampling at the falling edge where outputs are stable
   always @(negedge sys_clk)
   begin
      if (rxwr_access)
      begin
         if (wr_q.size() == 0)
            unexpected("rxwr");
         else
            check_packet("rxwr_packet", wr_q.pop_front(), rxwr_packet);
      end
      if (rxrd_access)
      begin
         if (rd_q.size() == 0)
            unexpected("rxrd");
         else
            check_packet("rxrd_packet", rd_q.pop_front(), rxrd_packet);
      end
      if (rxrr_access)
      begin
         if (rr_q.size() == 0)
            unexpected("rxrr");
         else
            check_packet("rxrr_packet", rr_q.pop_front(), rxrr_packet);
      end
   end

   task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = addr;
      mi_din  = data;
      @(negedge sys_clk);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = addr;
      @(negedge sys_clk);
      mi_en   = 1'b0;
      data    = mi_dout;                     // Registered one cycle after strobe
   endtask

   task automatic configure(input logic enable, input erx_pkg::erx_remap_e mode,
                            input logic [11:0] pattern, input logic [11:0] sel,
                            input logic [31:0] base);
      reg_write(erx_pkg::REG_REMAP, {4'd0, sel, 4'd0, pattern});
      reg_write(erx_pkg::REG_BASE, base);
      reg_write(erx_pkg::REG_CFG, {29'd0, mode, enable});
      cfg_mode    = mode;
      cfg_pattern = pattern;
      cfg_sel     = sel;
      cfg_base    = base;
   endtask

   task automatic make_packet(input logic write, input logic to_id,
                              output erx_pkg::erx_packet_t p);
      logic [31:0] r;
      p.srcaddr  = $random(seed);
      p.data     = $random(seed);
      p.dstaddr  = $random(seed);
      r          = $random(seed);
      p.ctrlmode = r[3:0];
      p.datamode = r[5:4];
      p.write    = write;
      p.access   = 1'b1;
      if (to_id)
         p.dstaddr[31:20] = `ERX_ID;
      else if (p.dstaddr[31:20] == `ERX_ID)
         p.dstaddr[31] = ~p.dstaddr[31];    // Steer clear of own ID
   endtask

   // Two beats and one idle beat with the frame low
   task automatic drive_frame(input erx_pkg::erx_packet_t p);
      link_frame = 1'b1;
      link_data  = {p.dstaddr, 24'd0, p.ctrlmode, p.datamode, p.write, 1'b0};
      @(negedge sys_clk);
      link_data  = {p.data, p.srcaddr};
      @(negedge sys_clk);
      link_frame = 1'b0;
      link_data  = '0;
      @(negedge sys_clk);
   endtask

   task automatic send_packet(input erx_pkg::erx_packet_t p);
      int n;
      n = 0;
      while ((p.write ? link_wr_wait : link_rd_wait) && n < TIMEOUT)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (p.write ? link_wr_wait : link_rd_wait)
         wait_failed("link wait to drop");
      predict(p);
      drive_frame(p);
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while ((wr_q.size() + rd_q.size() + rr_q.size()) != 0 && n < TIMEOUT)
      begin
         @(negedge sys_clk);
         n++;
      end
      if ((wr_q.size() + rd_q.size() + rr_q.size()) != 0)
         wait_failed("expected packets to arrive");
      repeat (8) @(negedge sys_clk);        // Room for stray accesses
   endtask

   task automatic run_tests();
      logic [31:0]          rdata;
      erx_pkg::erx_packet_t p;
      int                   n;
      arst_n = 1'b0;
      repeat (16) @(negedge sys_clk);
      arst_n = 1'b1;
      @(negedge sys_clk);
      // Link waits low after reset
      check_bit("wr_wait_reset", 1'b0, link_wr_wait);
      check_bit("rd_wait_reset", 1'b0, link_rd_wait);
      // Registers after reset and readback masks
      for (int a = 0; a < `ERX_NUM_REGS; a++)
      begin
         reg_read(4'(a), rdata);
         check_word("reset_value", 32'h0, rdata);
      end
      reg_write(erx_pkg::REG_CFG, 32'hffff_ffff);
      reg_write(erx_pkg::REG_REMAP, 32'hffff_ffff);
      reg_write(erx_pkg::REG_BASE, 32'ha5c3_1e97);
      reg_read(erx_pkg::REG_CFG, rdata);
      check_word("cfg_readback", 32'h0000_0007, rdata);
      reg_read(erx_pkg::REG_REMAP, rdata);
      check_word("remap_readback", 32'h0fff_0fff, rdata);
      reg_read(erx_pkg::REG_BASE, rdata);
      check_word("base_readback", 32'ha5c3_1e97, rdata);
      reg_read(4'd9, rdata);
      check_word("hole_readback", 32'h0, rdata);
      // Receiver disabled so the scoreboard flags any access
      configure(1'b0, erx_pkg::REMAP_OFF, 12'h0, 12'h0, 32'h0);
      for (int i = 0; i < 4; i++)
      begin
         make_packet(i[0], 1'b0, p);
         drive_frame(p);
      end
      repeat (20) @(negedge sys_clk);
      // Static remap on writes
      configure(1'b1, erx_pkg::REMAP_STATIC, 12'h3a5, 12'hf0f, 32'h0);
      for (int i = 0; i < 10; i++)
      begin
         make_packet(1'b1, 1'b0, p);
         send_packet(p);
      end
      wait_drained();
      // Offset remap on reads
      configure(1'b1, erx_pkg::REMAP_OFFSET, 12'h3a5, 12'hf0f, 32'h1000_4000);
      for (int i = 0; i < 10; i++)
      begin
         make_packet(1'b0, 1'b0, p);
         send_packet(p);
      end
      wait_drained();
      // Responses to own ID keep their address
      for (int i = 0; i < 4; i++)
      begin
         make_packet(1'b1, 1'b1, p);
         send_packet(p);
      end
      wait_drained();
      configure(1'b1, erx_pkg::REMAP_STATIC, 12'h123, 12'hfff, 32'h0);
      for (int i = 0; i < 4; i++)
      begin
         make_packet(1'b1, 1'b1, p);
         send_packet(p);
      end
      wait_drained();
      // Back-pressure on the write queue
      configure(1'b1, erx_pkg::REMAP_OFF, 12'h0, 12'h0, 32'h0);
      rxwr_wait = 1'b1;
      fork
         begin
            for (int i = 0; i < 24; i++)
            begin
               make_packet(1'b1, 1'b0, p);
               send_packet(p);
            end
         end
         begin
            n = 0;
            while (!link_wr_wait && n < TIMEOUT)
            begin
               @(negedge sys_clk);
               n++;
            end
            if (!link_wr_wait)
               wait_failed("link_wr_wait to rise");
            check_bit("rd_wait_held", 1'b0, link_rd_wait);  // Read queue stays open
            reg_read(erx_pkg::REG_STATUS, rdata);
            check_word("status_held", 32'h0000_0001, rdata);  // Only wr almost full
            rxwr_wait = 1'b0;
         end
      join
      wait_drained();
   endtask

   task automatic watch_run();
      int n;
      n = 0;
      while (!abort && n < RUN_LIMIT)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (!abort)
      begin
         errors++;
         $display("run did not finish within %0d cycles", RUN_LIMIT);
      end
   endtask

   initial
   begin
      arst_n     = 1'b0;
      link_frame = 1'b0;
      link_data  = '0;
      rxwr_wait  = 1'b0;
      rxrd_wait  = 1'b0;
      rxrr_wait  = 1'b0;
      mi_en      = 1'b0;
      mi_we      = 1'b0;
      mi_addr    = '0;
      mi_din     = '0;
      fork
         run_tests();
         watch_run();
      join_any
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== design/erx.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx (
   input  logic                  sys_clk,
   input  logic                  arst_n,
   input  logic                  link_frame,
   input  logic [63:0]           link_data,
   output logic                  link_wr_wait,
   output logic                  link_rd_wait,
   output logic                  rxwr_access,
   output logic [`ERX_PW-1:0]    rxwr_packet,
   input  logic                  rxwr_wait,
   output logic                  rxrd_access,
   output logic [`ERX_PW-1:0]    rxrd_packet,
   input  logic                  rxrd_wait,
   output logic                  rxrr_access,
   output logic [`ERX_PW-1:0]    rxrr_packet,
   input  logic                  rxrr_wait,
   input  logic                  mi_en,
   input  logic                  mi_we,
   input  logic [`ERX_MI_AW-1:0] mi_addr,
   input  logic [31:0]           mi_din,
   output logic [31:0]           mi_dout
);

   erx_pkg::erx_stage_t  proto_out;           // Assembled packet
   erx_pkg::erx_stage_t  remap_out;           // Classified and remapped
   erx_pkg::erx_packet_t push_pkt;
   logic                 wr_push, rd_push, rr_push;
   logic                 wr_afull, rd_afull, rr_afull;

   erx_cfg_if i_cfg_if ();

   erx_cfg i_cfg (
      .sys_clk, .arst_n, .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .fifo_level ({rr_afull, rd_afull, wr_afull}),  // Status bit 0 is wr
      .cfg        (i_cfg_if.src));

   erx_protocol i_protocol (
      .sys_clk, .arst_n, .link_frame, .link_data,
      .cfg (i_cfg_if.proto), .out (proto_out));

   erx_remap i_remap (
      .sys_clk, .arst_n, .in (proto_out), .cfg (i_cfg_if.remap), .out (remap_out));

   erx_disty i_disty (
      .sys_clk, .arst_n, .in (remap_out),
      .wr_afull, .rd_afull, .rr_afull, .wr_push, .rd_push, .rr_push,
      .push_pkt, .link_wr_wait, .link_rd_wait);

   // Packet ports take the struct as a flat vector
   erx_fifo i_wr_fifo (
      .sys_clk, .arst_n, .push (wr_push), .push_pkt, .afull (wr_afull),
      .wait_in (rxwr_wait), .access (rxwr_access), .packet (rxwr_packet));

   erx_fifo i_rd_fifo (
      .sys_clk, .arst_n, .push (rd_push), .push_pkt, .afull (rd_afull),
      .wait_in (rxrd_wait), .access (rxrd_access), .packet (rxrd_packet));

   erx_fifo i_rr_fifo (
      .sys_clk, .arst_n, .push (rr_push), .push_pkt, .afull (rr_afull),
      .wait_in (rxrr_wait), .access (rxrr_access), .packet (rxrr_packet));

endmodule

// ==== design/erx_fifo.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_fifo (
   input  logic                 sys_clk,
   input  logic                 arst_n,
   input  logic                 push,
   input  erx_pkg::erx_packet_t push_pkt,
   output logic                 afull,
   input  logic                 wait_in,      // Consumer back-pressure level
   output logic                 access,
   output erx_pkg::erx_packet_t packet
);

   localparam int PTR_W = $clog2(`ERX_FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   erx_pkg::erx_packet_t mem [`ERX_FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     count;               // Fill level
   logic                 full;
   logic                 push_ok;             // Push that fits
   logic                 pop;

   assign full    = (count == CNT_W'(`ERX_FIFO_DEPTH));
   assign afull   = (count >= CNT_W'(`ERX_FIFO_AFULL));
   assign push_ok = push && !full;            // Overflow is dropped
   assign pop     = !wait_in && (count != '0);

   always_ff @(posedge sys_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         access <= 1'b0;
      end
      else
      begin
         access <= pop;                       // Strobe on the cycle after pop
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;          // Depth is a power of two
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push_ok, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                        // Both or neither
         endcase
      end
   end

   // Storage and output packet
   always_ff @(posedge sys_clk)
   begin
      if (push_ok)
         mem[wr_ptr] <= push_pkt;
      if (pop)
         packet <= mem[rd_ptr];
   end

   // Sender ignored the link wait
   a_no_overflow : assert property (@(posedge sys_clk) disable iff (!arst_n)
      push |-> !full);

endmodule

// ==== design/erx_disty.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_disty (
   input  logic                 sys_clk,
   input  logic                 arst_n,
   input  erx_pkg::erx_stage_t  in,
   input  logic                 wr_afull,
   input  logic                 rd_afull,
   input  logic                 rr_afull,
   output logic                 wr_push,
   output logic                 rd_push,
   output logic                 rr_push,
   output erx_pkg::erx_packet_t push_pkt,    // Shared by all three queues
   output logic                 link_wr_wait,
   output logic                 link_rd_wait
);

   // Push strobes and sender waits
   always_ff @(posedge sys_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_push      <= 1'b0;
         rd_push      <= 1'b0;
         rr_push      <= 1'b0;
         link_wr_wait <= 1'b0;
         link_rd_wait <= 1'b0;
      end
      else
      begin
         wr_push      <= in.valid && (in.dest == erx_pkg::DEST_WR);
         rd_push      <= in.valid && (in.dest == erx_pkg::DEST_RD);
         rr_push      <= in.valid && (in.dest == erx_pkg::DEST_RR);
         link_wr_wait <= wr_afull || rr_afull;  // Writes also carry responses
         link_rd_wait <= rd_afull;
      end
   end

   always_ff @(posedge sys_clk)
   begin
      if (in.valid)
         push_pkt <= in.pkt;
   end

   // Each packet lands in exactly one queue
   a_one_push : assert property (@(posedge sys_clk) disable iff (!arst_n)
      in.valid |=> $onehot({wr_push, rd_push, rr_push}));

endmodule

// ==== design/erx_remap.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_remap (
   input  logic                sys_clk,
   input  logic                arst_n,
   input  erx_pkg::erx_stage_t in,
   erx_cfg_if.remap            cfg,
   output erx_pkg::erx_stage_t out
);

   logic                 is_rr;               // Write aimed at this receiver
   erx_pkg::erx_dest_e   dest_c;
   erx_pkg::erx_packet_t pkt_c;               // Packet with new address
   logic                 valid_q;
   erx_pkg::erx_dest_e   dest_q;
   erx_pkg::erx_packet_t pkt_q;

   // Uses the address as it arrived from the link
   assign is_rr = in.pkt.write && (in.pkt.dstaddr[`ERX_AW-1:20] == `ERX_ID);

   always_comb
   begin
      if (!in.pkt.write)
         dest_c = erx_pkg::DEST_RD;
      else if (is_rr)
         dest_c = erx_pkg::DEST_RR;
      else
         dest_c = erx_pkg::DEST_WR;

      pkt_c = in.pkt;
      if (!is_rr)                             // Responses keep their address
      begin
         case (cfg.remap_mode)
            erx_pkg::REMAP_STATIC:
               pkt_c.dstaddr[`ERX_AW-1:20] = (cfg.remap_pattern & cfg.remap_sel) |
                                             (in.pkt.dstaddr[`ERX_AW-1:20] & ~cfg.remap_sel);
            erx_pkg::REMAP_OFFSET:
               pkt_c.dstaddr = in.pkt.dstaddr + cfg.remap_base;  // Wraps at 32 bits
            default: ;                        // Off leaves the address unchanged
         endcase
      end
   end

   always_ff @(posedge sys_clk or negedge arst_n)
   begin
      if (!arst_n)
         valid_q <= 1'b0;
      else
         valid_q <= in.valid;
   end

   // Payload only moves with a valid word
   always_ff @(posedge sys_clk)
   begin
      if (in.valid)
      begin
         dest_q <= dest_c;
         pkt_q  <= pkt_c;
      end
   end

   assign out = '{valid: valid_q, dest: dest_q, pkt: pkt_q};

endmodule

// ==== design/erx_protocol.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_protocol (
   input  logic                sys_clk,
   input  logic                arst_n,
   input  logic                link_frame,
   input  logic [63:0]         link_data,
   erx_cfg_if.proto            cfg,
   output erx_pkg::erx_stage_t out
);

   erx_pkg::erx_beat_e   state;               // Beat phase
   logic                 hdr_load;            // Header beat accepted
   logic                 data_load;           // Data beat accepted
   logic                 valid_q;
   erx_pkg::erx_packet_t pkt_q;
   logic [`ERX_AW-1:0]   hdr_dstaddr;         // Held from beat 0
   logic [3:0]           hdr_ctrlmode;
   logic [1:0]           hdr_datamode;
   logic                 hdr_write;

   assign hdr_load  = cfg.rx_enable && link_frame && (state == erx_pkg::IDLE_BEAT);
   assign data_load = cfg.rx_enable && link_frame && (state == erx_pkg::HEAD_BEAT);

   // Low frame or disable restarts the phase
   always_ff @(posedge sys_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= erx_pkg::IDLE_BEAT;
         valid_q <= 1'b0;
      end
      else
      begin
         valid_q <= data_load;                // One cycle pulse after beat 1
         if (hdr_load)
            state <= erx_pkg::HEAD_BEAT;
         else
            state <= erx_pkg::IDLE_BEAT;      // Data beat done or frame dropped
      end
   end

   // Header latch and packet assembly
   always_ff @(posedge sys_clk)
   begin
      if (hdr_load)
      begin
         hdr_dstaddr  <= link_data[63:32];
         hdr_ctrlmode <= link_data[7:4];
         hdr_datamode <= link_data[3:2];
         hdr_write    <= link_data[1];
      end
      if (data_load)
      begin
         pkt_q.srcaddr  <= link_data[31:0];
         pkt_q.data     <= link_data[63:32];
         pkt_q.dstaddr  <= hdr_dstaddr;
         pkt_q.ctrlmode <= hdr_ctrlmode;
         pkt_q.datamode <= hdr_datamode;
         pkt_q.write    <= hdr_write;
         pkt_q.access   <= 1'b1;
      end
   end

   // Dest is filled in by the remap stage
   assign out = '{valid: valid_q, dest: erx_pkg::DEST_WR, pkt: pkt_q};

endmodule

// ==== design/erx_cfg.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_cfg (
   input  logic                  sys_clk,
   input  logic                  arst_n,
   input  logic                  mi_en,
   input  logic                  mi_we,
   input  logic [`ERX_MI_AW-1:0] mi_addr,
   input  logic [31:0]           mi_din,
   output logic [31:0]           mi_dout,
   input  logic [2:0]            fifo_level,   // {rr, rd, wr} almost full
   erx_cfg_if.src                cfg
);

   logic        wr_en;                        // Register write strobe
   logic        rd_en;                        // Readback strobe
   logic [31:0] rd_data;                      // Selected readback word

   assign wr_en = mi_en && mi_we;
   assign rd_en = mi_en && !mi_we;

   // Register writes
   always_ff @(posedge sys_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cfg.rx_enable     <= 1'b0;
         cfg.remap_mode    <= erx_pkg::REMAP_OFF;
         cfg.remap_pattern <= '0;
         cfg.remap_sel     <= '0;
         cfg.remap_base    <= '0;
      end
      else if (wr_en)
      begin
         case (erx_pkg::erx_reg_e'(mi_addr))
            erx_pkg::REG_CFG:
            begin
               cfg.rx_enable  <= mi_din[0];
               cfg.remap_mode <= erx_pkg::erx_remap_e'(mi_din[2:1]);
            end
            erx_pkg::REG_REMAP:
            begin
               cfg.remap_pattern <= mi_din[11:0];
               cfg.remap_sel     <= mi_din[27:16];
            end
            erx_pkg::REG_BASE: cfg.remap_base <= mi_din;
            default: ;                        // Status and holes are read only
         endcase
      end
   end

   // Readback select with unused bits as 0
   always_comb
   begin
      case (erx_pkg::erx_reg_e'(mi_addr))
         erx_pkg::REG_CFG:    rd_data = {29'd0, cfg.remap_mode, cfg.rx_enable};
         erx_pkg::REG_REMAP:  rd_data = {4'd0, cfg.remap_sel, 4'd0, cfg.remap_pattern};
         erx_pkg::REG_BASE:   rd_data = cfg.remap_base;
         erx_pkg::REG_STATUS: rd_data = {29'd0, fifo_level};
         default:             rd_data = '0;  // Out of map reads 0
      endcase
   end

   // Registered readback that holds between reads
   always_ff @(posedge sys_clk or negedge arst_n)
   begin
      if (!arst_n)
         mi_dout <= '0;
      else if (rd_en)
         mi_dout <= rd_data;
   end

   // Write strobe only qualifies an enabled access
   a_we_needs_en : assert property (@(posedge sys_clk) disable iff (!arst_n)
      mi_we |-> mi_en);

endmodule

// ==== design/erx_cfg_if.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

interface erx_cfg_if;

   logic                   rx_enable;         // Accept link beats
   erx_pkg::erx_remap_e    remap_mode;
   logic [11:0]            remap_pattern;     // Replacement for addr 31:20
   logic [11:0]            remap_sel;         // Bits of pattern to apply
   logic [`ERX_AW-1:0]     remap_base;        // Added in offset mode

   modport src   (output rx_enable, remap_mode, remap_pattern, remap_sel, remap_base);

   modport proto (input rx_enable);

   modport remap (input remap_mode, remap_pattern, remap_sel, remap_base);

endinterface

// ==== design/erx_pkg.sv ====
package erx_pkg;

`include "erx_settings.svh"

   // Transaction packet with srcaddr in the top bits
   typedef struct packed {
      logic [`ERX_AW-1:0] srcaddr;            // Return address
      logic [`ERX_AW-1:0] data;               // Write data
      logic [`ERX_AW-1:0] dstaddr;            // Target address
      logic [3:0]         ctrlmode;           // Passed through untouched
      logic [1:0]         datamode;           // Transfer size
      logic               write;              // 1 for write, 0 for read
      logic               access;             // Always 1 for a real packet
   } erx_packet_t;

   // Target queue
   typedef enum logic [1:0] {
      DEST_WR = 2'd0,                         // Write
      DEST_RD = 2'd1,                         // Read request
      DEST_RR = 2'd2                          // Read response
   } erx_dest_e;

   // Address remap mode where 3 acts as off
   typedef enum logic [1:0] {
      REMAP_OFF    = 2'd0,
      REMAP_STATIC = 2'd1,
      REMAP_OFFSET = 2'd2
   } erx_remap_e;

   // Register map with one word per address
   typedef enum logic [`ERX_MI_AW-1:0] {
      REG_CFG    = 4'd0,                      // Enable and remap mode
      REG_REMAP  = 4'd1,                      // Pattern and select
      REG_BASE   = 4'd2,                      // Offset for offset mode
      REG_STATUS = 4'd3                       // Almost-full levels, read only
   } erx_reg_e;

   // Link beat phase
   typedef enum logic {
      IDLE_BEAT = 1'b0,                       // Expecting header beat
      HEAD_BEAT = 1'b1                        // Header held, expecting data beat
   } erx_beat_e;

   // Word between pipeline stages
   typedef struct packed {
      logic        valid;
      erx_dest_e   dest;                      // Set by remap stage
      erx_packet_t pkt;
   } erx_stage_t;

endpackage

// ==== include/erx_settings.svh ====
`ifndef ERX_SETTINGS_SVH
`define ERX_SETTINGS_SVH

// Packet and word widths
`define ERX_PW 104
`define ERX_AW 32

// Output queue sizing
`define ERX_FIFO_DEPTH 16
// Leaves room for packets still in the three pipeline stages
`define ERX_FIFO_AFULL 12

// Top address bits that select this receiver
`define ERX_ID 12'h800

// Register file
`define ERX_MI_AW 4
`define ERX_NUM_REGS 4

`endif
